/* common/if_pkg.sv */
package if_pkg;

	localparam int unsigned ADDR_W = 32;
	localparam logic [ADDR_W-1:0] DM_HALT_ADDR = 32'h1a11_0800;
	localparam logic [ADDR_W-1:0] DM_EXC_ADDR = 32'h1a11_0808;
	localparam int unsigned VEC_ALIGN_W = 8;
	localparam logic [VEC_ALIGN_W-1:0] BOOT_OFFSET = 8'h80;
	localparam int unsigned FIFO_DEPTH = 2;
	localparam int unsigned MAX_OUTSTANDING = 2;
	localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int unsigned OUT_CNT_W = $clog2(MAX_OUTSTANDING + 1);
	localparam int unsigned OUT_PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

	typedef enum logic [2:0] {
		PC_BOOT = 3'd0,
		PC_JUMP = 3'd1,
		PC_EXC  = 3'd2,
		PC_ERET = 3'd3,
		PC_DRET = 3'd4
	} pc_sel_e;

	typedef enum logic [1:0] {
		EXC_PC_EXC     = 2'd0,
		EXC_PC_IRQ     = 2'd1,
		EXC_PC_DBD     = 2'd2,
		EXC_PC_DBG_EXC = 2'd3
	} exc_pc_sel_e;

	typedef struct packed {
		logic              req;
		logic [ADDR_W-1:0] addr;
	} instr_bus_req_t;

	typedef struct packed {
		logic        gnt;
		logic        rvalid;
		logic [31:0] rdata;
		logic        err; // pmp error already merged in.
	} instr_bus_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] mepc;
		logic [ADDR_W-1:0] depc;
		logic [ADDR_W-1:0] mtvec;
	} csr_pc_t;

	typedef struct packed {
		logic [31:0]       rdata;
		logic [ADDR_W-1:0] addr;
		logic              err;
	} fetch_entry_t;

endpackage

/* hdl/pc_sel.sv */
`timescale 1ns/1ps

module pc_sel import if_pkg::*; (
	input  logic [ADDR_W-1:0] boot_addr_i,
	input  logic [ADDR_W-1:0] jump_target_i,
	input  csr_pc_t           csr_i,
	input  pc_sel_e           pc_mux_i,
	input  exc_pc_sel_e       exc_pc_mux_i,
	input  logic [4:0]        exc_cause_i,
	input  logic              pc_set_i,
	output logic [ADDR_W-1:0] fetch_addr_o,
	output logic              csr_mtvec_init_o
);

	logic [ADDR_W-1:0] exc_pc;
	logic [ADDR_W-1:0] boot_pc;

	assign boot_pc = {boot_addr_i[ADDR_W-1:VEC_ALIGN_W], BOOT_OFFSET};

	always_comb begin
		case (exc_pc_mux_i)
			EXC_PC_EXC:     exc_pc = {csr_i.mtvec[ADDR_W-1:VEC_ALIGN_W], VEC_ALIGN_W'(0)};
			EXC_PC_IRQ:     exc_pc = {csr_i.mtvec[ADDR_W-1:VEC_ALIGN_W], 1'b0, exc_cause_i, 2'b00};
			EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
			EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
			default:        exc_pc = {csr_i.mtvec[ADDR_W-1:VEC_ALIGN_W], VEC_ALIGN_W'(0)};
		endcase
	end

	always_comb begin
		case (pc_mux_i)
			PC_BOOT: fetch_addr_o = boot_pc;
			PC_JUMP: fetch_addr_o = jump_target_i;
			PC_EXC:  fetch_addr_o = exc_pc;
			PC_ERET: fetch_addr_o = csr_i.mepc;
			PC_DRET: fetch_addr_o = csr_i.depc;
			default: fetch_addr_o = boot_pc;
		endcase
	end

	// boot redirect also tells the csr file to reload mtvec.
	assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

	// jump and csr sources come from outside, all must be word aligned.
	fetch_addr_aligned_a: assert final (pc_set_i !== 1'b1 || fetch_addr_o[1:0] == 2'b00);

endmodule

/* prefetch/fetch_fifo.sv */
`timescale 1ns/1ps

module fetch_fifo import if_pkg::*; #(
	parameter int unsigned DEPTH = FIFO_DEPTH
) (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         flush_i,
	input  logic                         push_i,
	input  fetch_entry_t                 push_data_i,
	input  logic                         pop_ready_i,
	output logic                         full_o,
	output logic [$clog2(DEPTH + 1)-1:0] count_o,
	output logic                         valid_o,
	output fetch_entry_t                 data_o
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	fetch_entry_t     mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign valid_o = (count_q != '0);
	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign count_o = count_q;
	assign data_o  = mem_q[rd_ptr_q];
	assign pop     = valid_o & pop_ready_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (flush_i) begin // redirect drops everything.
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
			if (push_i && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i && !flush_i) begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

	no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		push_i && full_o && !flush_i |-> pop);

endmodule

/* prefetch/prefetch_buffer.sv */
`timescale 1ns/1ps

module prefetch_buffer import if_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              req_i,
	input  logic              branch_i,
	input  logic [ADDR_W-1:0] branch_addr_i,
	input  logic              ready_i,
	output logic              valid_o,
	output fetch_entry_t      entry_o,
	output instr_bus_req_t    bus_req_o,
	input  instr_bus_rsp_t    bus_rsp_i,
	output logic              busy_o
);

	logic [ADDR_W-1:0]     fetch_addr_q;
	logic [ADDR_W-1:0]     req_addr;
	logic [ADDR_W-1:0]     addr_queue_q [MAX_OUTSTANDING];
	logic [OUT_PTR_W-1:0]  head_q;
	logic [OUT_PTR_W-1:0]  tail_q;
	logic [OUT_CNT_W-1:0]  out_cnt_q;
	logic [OUT_CNT_W-1:0]  discard_cnt_q;
	logic [OUT_CNT_W-1:0]  live_cnt;
	logic [FIFO_CNT_W-1:0] fifo_cnt;
	logic                  room_ok;
	logic                  granted;
	logic                  push;
	logic                  fifo_valid;
	fetch_entry_t          push_entry;

	function automatic logic [OUT_PTR_W-1:0] ptr_inc(input logic [OUT_PTR_W-1:0] ptr);
		if (ptr == OUT_PTR_W'(MAX_OUTSTANDING - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a redirect goes out at once, the old stream is already dead.
	assign req_addr = branch_i ? branch_addr_i : fetch_addr_q;
	assign live_cnt = out_cnt_q - discard_cnt_q;
	assign room_ok  = branch_i || (int'(live_cnt) + int'(fifo_cnt) < int'(FIFO_DEPTH));

	assign bus_req_o.req  = req_i && (out_cnt_q < OUT_CNT_W'(MAX_OUTSTANDING)) && room_ok;
	assign bus_req_o.addr = req_addr;
	assign granted        = bus_req_o.req & bus_rsp_i.gnt;

	// responses in a redirect cycle always belong to the old stream.
	assign push = bus_rsp_i.rvalid && (discard_cnt_q == '0) && !branch_i;
	assign push_entry.rdata = bus_rsp_i.rdata;
	assign push_entry.addr  = addr_queue_q[head_q];
	assign push_entry.err   = bus_rsp_i.err;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			fetch_addr_q  <= '0;
			head_q        <= '0;
			tail_q        <= '0;
			out_cnt_q     <= '0;
			discard_cnt_q <= '0;
		end else begin
			if (granted) begin
				fetch_addr_q <= req_addr + ADDR_W'(4);
				tail_q       <= ptr_inc(tail_q);
			end else if (branch_i) begin
				fetch_addr_q <= branch_addr_i;
			end
			if (bus_rsp_i.rvalid) head_q <= ptr_inc(head_q);
			out_cnt_q <= out_cnt_q + OUT_CNT_W'(granted) - OUT_CNT_W'(bus_rsp_i.rvalid);
			if (branch_i) begin
				discard_cnt_q <= out_cnt_q - OUT_CNT_W'(bus_rsp_i.rvalid);
			end else if (bus_rsp_i.rvalid && discard_cnt_q != '0) begin
				discard_cnt_q <= discard_cnt_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (granted) begin
			addr_queue_q[tail_q] <= req_addr;
		end
	end

	fetch_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fetch_fifo (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.flush_i     (branch_i),
		.push_i      (push),
		.push_data_i (push_entry),
		.pop_ready_i (ready_i),
		.full_o      (),
		.count_o     (fifo_cnt),
		.valid_o     (fifo_valid),
		.data_o      (entry_o)
	);

	assign valid_o = fifo_valid & ~branch_i; // hide stale head.
	assign busy_o  = (out_cnt_q != '0);

	out_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_cnt_q <= OUT_CNT_W'(MAX_OUTSTANDING));

	rsp_expected_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_rsp_i.rvalid |-> out_cnt_q != '0);

endmodule

/* hdl/if_id_reg.sv */
`timescale 1ns/1ps

module if_id_reg import if_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              fetch_valid_i,
	input  fetch_entry_t      fetch_entry_i,
	input  logic              id_in_ready_i,
	input  logic              pc_set_i,
	input  logic              instr_valid_clear_i,
	output logic              instr_valid_id_o,
	output logic              instr_new_id_o,
	output logic [31:0]       instr_rdata_id_o,
	output logic              instr_fetch_err_o,
	output logic [ADDR_W-1:0] pc_id_o,
	output logic              pc_mismatch_alert_o
);

	logic transfer;
	logic valid_q;
	logic new_q;
	logic seq_q;

	assign transfer = fetch_valid_i & id_in_ready_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
			new_q   <= 1'b0;
			seq_q   <= 1'b0;
		end else begin
			valid_q <= (transfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);
			new_q   <= transfer;
			seq_q   <= (seq_q | transfer) & ~pc_set_i; // any redirect breaks the chain.
		end
	end

	always_ff @(posedge clk_i) begin
		if (transfer) begin
			instr_rdata_id_o  <= fetch_entry_i.rdata;
			instr_fetch_err_o <= fetch_entry_i.err;
			pc_id_o           <= fetch_entry_i.addr;
		end
	end

	assign instr_valid_id_o = valid_q;
	assign instr_new_id_o   = new_q;

	// all instructions are 32 bit, so the next pc is always +4.
	assign pc_mismatch_alert_o = seq_q & fetch_valid_i &
		(fetch_entry_i.addr != pc_id_o + ADDR_W'(4));

	// head entry must hold while ID stalls.
	entry_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fetch_valid_i && !id_in_ready_i |=> !fetch_valid_i || $stable(fetch_entry_i));

endmodule

/* hdl/if_stage.sv */
`timescale 1ns/1ps

module if_stage import if_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic [ADDR_W-1:0] boot_addr_i,
	input  logic              req_i,
	output instr_bus_req_t    instr_bus_req_o,
	input  instr_bus_rsp_t    instr_bus_rsp_i,
	input  logic              pc_set_i,
	input  pc_sel_e           pc_mux_i,
	input  exc_pc_sel_e       exc_pc_mux_i,
	input  logic [4:0]        exc_cause_i,
	input  logic [ADDR_W-1:0] jump_target_i,
	input  csr_pc_t           csr_i,
	input  logic              id_in_ready_i,
	input  logic              instr_valid_clear_i,
	output logic              instr_valid_id_o,
	output logic              instr_new_id_o,
	output logic [31:0]       instr_rdata_id_o,
	output logic              instr_fetch_err_o,
	output logic [ADDR_W-1:0] pc_id_o,
	output logic              pc_mismatch_alert_o,
	output logic [ADDR_W-1:0] pc_if_o,
	output logic              csr_mtvec_init_o,
	output logic              if_busy_o
);

	logic [ADDR_W-1:0] fetch_addr;
	logic              fetch_valid;
	fetch_entry_t      fetch_entry;

	pc_sel u_pc_sel (
		.boot_addr_i      (boot_addr_i),
		.jump_target_i    (jump_target_i),
		.csr_i            (csr_i),
		.pc_mux_i         (pc_mux_i),
		.exc_pc_mux_i     (exc_pc_mux_i),
		.exc_cause_i      (exc_cause_i),
		.pc_set_i         (pc_set_i),
		.fetch_addr_o     (fetch_addr),
		.csr_mtvec_init_o (csr_mtvec_init_o)
	);

	prefetch_buffer u_prefetch_buffer (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.req_i         (req_i),
		.branch_i      (pc_set_i),
		.branch_addr_i (fetch_addr),
		.ready_i       (id_in_ready_i),
		.valid_o       (fetch_valid),
		.entry_o       (fetch_entry),
		.bus_req_o     (instr_bus_req_o),
		.bus_rsp_i     (instr_bus_rsp_i),
		.busy_o        (if_busy_o)
	);

	if_id_reg u_if_id_reg (
		.clk_i               (clk_i),
		.rst_ni              (rst_ni),
		.fetch_valid_i       (fetch_valid),
		.fetch_entry_i       (fetch_entry),
		.id_in_ready_i       (id_in_ready_i),
		.pc_set_i            (pc_set_i),
		.instr_valid_clear_i (instr_valid_clear_i),
		.instr_valid_id_o    (instr_valid_id_o),
		.instr_new_id_o      (instr_new_id_o),
		.instr_rdata_id_o    (instr_rdata_id_o),
		.instr_fetch_err_o   (instr_fetch_err_o),
		.pc_id_o             (pc_id_o),
		.pc_mismatch_alert_o (pc_mismatch_alert_o)
	);

	assign pc_if_o = fetch_entry.addr;

endmodule

/* tests/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem import if_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic [ADDR_W-1:0] err_lo_i,
	input  logic [ADDR_W-1:0] err_hi_i,
	input  instr_bus_req_t    bus_req_i,
	output instr_bus_rsp_t    bus_rsp_o
);

	logic [ADDR_W-1:0] addr_q [$];
	int unsigned       wait_q [$];
	logic [ADDR_W-1:0] rsp_addr;

	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			addr_q.delete();
			wait_q.delete();
			bus_rsp_o <= '0;
		end else begin
			bus_rsp_o.rvalid <= 1'b0;
			if (wait_q.size() != 0 && wait_q[0] == 0) begin // oldest request answers first.
				rsp_addr = addr_q.pop_front();
				void'(wait_q.pop_front());
				bus_rsp_o.rvalid <= 1'b1;
				bus_rsp_o.rdata  <= rsp_addr ^ 32'ha5a5_0000;
				bus_rsp_o.err    <= (rsp_addr >= err_lo_i) && (rsp_addr < err_hi_i);
			end else if (wait_q.size() != 0) begin
				wait_q[0] = wait_q[0] - 1;
			end
			// gnt here is still the value seen by the DUT this cycle.
			if (bus_req_i.req && bus_rsp_o.gnt) begin
				addr_q.push_back(bus_req_i.addr);
				wait_q.push_back($urandom_range(0, 2));
			end
			bus_rsp_o.gnt <= ($urandom_range(0, 3) != 0);
		end
	end

endmodule

/* tests/tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage import if_pkg::*; ();

	localparam int unsigned RESET_CYCLES = 8;
	localparam int unsigned TEST_INSTRS = 125;
	localparam logic [ADDR_W-1:0] ERR_LO = 32'h0000_6000;
	localparam logic [ADDR_W-1:0] ERR_HI = 32'h0000_6010;

	logic              clk_i, rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
	logic [ADDR_W-1:0] boot_addr_i, jump_target_i, pc_id_o, pc_if_o;
	logic [31:0]       instr_rdata_id_o;
	logic [4:0]        exc_cause_i;
	pc_sel_e           pc_mux_i;
	exc_pc_sel_e       exc_pc_mux_i;
	csr_pc_t           csr_i;
	instr_bus_req_t    instr_bus_req_o;
	instr_bus_rsp_t    instr_bus_rsp_i;
	logic              instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
	logic              pc_mismatch_alert_o, csr_mtvec_init_o, if_busy_o;
	logic [ADDR_W-1:0] exp_pc, redirect_pc, pc_if_prev;
	logic              stream_live, random_ready;
	int                checks, errors, captures, err_fetches;

	if_stage dut (.*);

	instr_mem u_instr_mem (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.err_lo_i  (ERR_LO),
		.err_hi_i  (ERR_HI),
		.bus_req_i (instr_bus_req_o),
		.bus_rsp_o (instr_bus_rsp_i)
	);

	function automatic logic [31:0] expected_word(input logic [ADDR_W-1:0] addr);
		return addr ^ 32'ha5a5_0000;
	endfunction

	function automatic logic expected_err(input logic [ADDR_W-1:0] addr);
		return (addr >= ERR_LO) && (addr < ERR_HI);
	endfunction

	function automatic logic [ADDR_W-1:0] expected_vector(input pc_sel_e mux,
			input exc_pc_sel_e emux, input logic [4:0] cause, input csr_pc_t csr,
			input logic [ADDR_W-1:0] boot, input logic [ADDR_W-1:0] jump);
		logic [ADDR_W-1:0] base;
		logic [ADDR_W-1:0] vec;
		base = csr.mtvec & ~32'h0000_00ff;
		case (emux)
			EXC_PC_EXC: vec = base;
			EXC_PC_IRQ: vec = base + 32'(cause) * 4;
			EXC_PC_DBD: vec = DM_HALT_ADDR;
			default:    vec = DM_EXC_ADDR;
		endcase
		case (mux)
			PC_BOOT: return (boot & ~32'h0000_00ff) | 32'h0000_0080;
			PC_JUMP: return jump;
			PC_EXC:  return vec;
			PC_ERET: return csr.mepc;
			default: return csr.depc;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic redirect(input pc_sel_e mux, input exc_pc_sel_e emux, input logic [4:0] cause,
			input logic [ADDR_W-1:0] target);
		@(posedge clk_i);
		pc_set_i      <= 1'b1;
		req_i         <= 1'b1;
		pc_mux_i      <= mux;
		exc_pc_mux_i  <= emux;
		exc_cause_i   <= cause;
		jump_target_i <= target;
		redirect_pc   <= expected_vector(mux, emux, cause, csr_i, boot_addr_i, target);
		@(posedge clk_i);
		pc_set_i <= 1'b0;
	endtask

	task automatic wait_captures(input int n);
		int target;
		target = captures + n;
		while (captures < target) begin
			@(posedge clk_i);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (errors == err_start) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - err_start);
	endtask

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		if (random_ready) id_in_ready_i <= ($urandom_range(0, 1) == 1);
	end

	// every capture in ID must continue the current stream.
	always @(posedge clk_i) begin
		if (rst_ni) begin
			if (instr_new_id_o && !stream_live) begin
				errors++;
				$display("Error at %0t: instruction reached ID before any fetch was started", $time);
			end else if (instr_new_id_o) begin
				check_word("pc_id_o", pc_id_o, exp_pc);
				check_word("pc_if_o", pc_if_prev, exp_pc); // held in the transfer cycle.
				check_word("instr_rdata_id_o", instr_rdata_id_o, expected_word(exp_pc));
				check_flag("instr_fetch_err_o", instr_fetch_err_o, expected_err(exp_pc));
				check_flag("instr_valid_id_o", instr_valid_id_o, 1'b1);
				if (instr_fetch_err_o) err_fetches++;
				exp_pc = exp_pc + 32'd4;
			end
			if (instr_new_id_o) captures++;
			if (instr_new_id_o || pc_mismatch_alert_o)
				check_flag("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
			if (pc_set_i || csr_mtvec_init_o)
				check_flag("csr_mtvec_init_o", csr_mtvec_init_o, pc_set_i && pc_mux_i == PC_BOOT);
			if (pc_set_i) begin // first new pc is the redirect target.
				exp_pc = redirect_pc;
				stream_live = 1'b1;
			end
			pc_if_prev = pc_if_o;
		end
	end

	initial begin
		repeat (RESET_CYCLES + 200 * TEST_INSTRS) @(posedge clk_i);
		$display("Error: watchdog expired, the DUT stopped delivering instructions");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int unsigned seed;
		int start;
		seed = $urandom(65);
		{checks, errors, captures, err_fetches} = '0;
		{stream_live, random_ready, exp_pc, redirect_pc} = '0;
		rst_ni = 1'b0;
		req_i = 1'b0;
		pc_set_i = 1'b0;
		id_in_ready_i = 1'b1;
		instr_valid_clear_i = 1'b0;
		boot_addr_i = 32'h0000_1055;
		jump_target_i = '0;
		exc_cause_i = '0;
		pc_mux_i = PC_BOOT;
		exc_pc_mux_i = EXC_PC_EXC;
		csr_i.mepc = 32'h0000_3010;
		csr_i.depc = 32'h0000_5020;
		csr_i.mtvec = 32'h0000_2001;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);
		start = errors;
		check_flag("instr_bus_req_o.req", instr_bus_req_o.req, 1'b0);
		check_flag("instr_valid_id_o", instr_valid_id_o, 1'b0);
		check_flag("instr_new_id_o", instr_new_id_o, 1'b0);
		check_flag("if_busy_o", if_busy_o, 1'b0);
		check_flag("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
		check_flag("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);
		redirect(PC_BOOT, EXC_PC_EXC, 5'd0, '0);
		wait_captures(1);
		report_test("boot", start);
		start = errors;
		wait_captures(40);
		report_test("sequential stream", start);
		start = errors;
		redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_4000);
		wait_captures(8);
		report_test("jump redirect", start);
		start = errors;
		for (int i = 0; i < 4; i++) begin
			redirect(PC_EXC, exc_pc_sel_e'(i), 5'd11, '0);
			wait_captures(4);
		end
		redirect(PC_ERET, EXC_PC_EXC, 5'd0, '0);
		wait_captures(4);
		redirect(PC_DRET, EXC_PC_EXC, 5'd0, '0);
		wait_captures(4);
		report_test("exception vectors", start);
		start = errors;
		err_fetches = 0;
		redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_5ff0);
		wait_captures(12);
		if (err_fetches != 4) begin
			errors++;
			$display("Error at %0t: error window fetches is %0d, expected 4", $time, err_fetches);
		end
		report_test("bus error", start);
		start = errors;
		@(posedge clk_i);
		random_ready <= 1'b1;
		redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_8000);
		wait_captures(40);
		report_test("back-pressure", start);
		$display("checks %0d, errors %0d, captures %0d", checks, errors, captures);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* if_stage.f */
common/if_pkg.sv
hdl/pc_sel.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
hdl/if_id_reg.sv
hdl/if_stage.sv
tests/instr_mem.sv
tests/tb_if_stage.sv
